// File: files.f
+incdir+source
source/sample_gen_pkg.sv
source/batch_if.sv
source/sample_ctrl.sv
source/lfsr_bank.sv
source/triangle_gen.sv
source/batch_pipe.sv
source/sample_gen_top.sv
bench/tb_sample_gen.sv

// File: Bender.yml
package:
  name: sample_gen

sources:
  - include_dirs:
      - source
    files:
      - source/sample_gen_pkg.sv
      - source/batch_if.sv
      - source/sample_ctrl.sv
      - source/lfsr_bank.sv
      - source/triangle_gen.sv
      - source/batch_pipe.sv
      - source/sample_gen_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_sample_gen.sv

// File: bench/tb_sample_gen.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module tb_sample_gen import sample_gen_pkg::*; ();

	localparam int CLK_NS     = 4;
	localparam int N_IDLE     = 10;
	localparam int N_NOISE    = 40;
	localparam int N_TRI      = 60;
	localparam int N_RAND     = 120;
	localparam int N_RESUME   = 30;
	localparam int N_AXI      = 14;
	localparam int AXI_CYCLES = 4;
	localparam int N_DRAIN    = `DAC_STAGES + 2;
	// six run phases, each closed by one idle cycle.
	localparam int TOTAL_CYCLES = 4 + N_IDLE + N_NOISE + N_TRI + N_RAND + 2 * N_RESUME + 6
		+ N_AXI * AXI_CYCLES + 2 * N_DRAIN;
	localparam int LIMIT_NS = TOTAL_CYCLES * CLK_NS + 200;

	typedef logic [`SAMPLE_W:0] phase_t;

	logic                     clk, rst_n, dac_rdy, dac_valid;
	logic [`AXI_ADDR_W-1:0]   s_awaddr, s_araddr;
	logic [`AXI_DATA_W-1:0]   s_wdata, s_rdata;
	logic [`AXI_DATA_W/8-1:0] s_wstrb;
	logic                     s_awvalid, s_awready, s_wvalid, s_wready;
	logic                     s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
	logic [1:0]               s_bresp, s_rresp;
	batch_t                   dac_batch;

	// reference model state.
	logic [1:0]  m_mode;
	sample_t     m_seed;
	sample_t     m_step;
	batch_t      m_lanes;
	phase_t      m_phase;
	logic [31:0] rng;

	batch_t      exp_q [$];
	int          exp_cyc_q [$];
	batch_t      exp_b;
	int          exp_c;
	int          cyc = 0;
	int          errors;
	int          n_valid;
	logic [31:0] rd;

	sample_gen_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_NS / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// a one shifted out of bit 0 folds back into taps 16, 14, 13 and 11.
	function automatic sample_t lfsr_step(input sample_t s);
		sample_t n;
		n = {1'b0, s[`SAMPLE_W-1:1]};
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	function automatic sample_t seed_of_lane(input sample_t seed, input int lane);
		sample_t s;
		s = seed + sample_t'(lane);
		return (s == '0) ? sample_t'(1) : s;
	endfunction

	// the upper half of the phase range runs the ramp downwards.
	function automatic sample_t tri_sample(input phase_t phase, input sample_t step, input int lane);
		phase_t p;
		p = phase + phase_t'(lane * step);
		return p[`SAMPLE_W] ? ~p[`SAMPLE_W-1:0] : p[`SAMPLE_W-1:0];
	endfunction

	function automatic batch_t expected_batch(input logic [1:0] mode, input batch_t lanes,
			input phase_t phase, input sample_t step);
		batch_t b;
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			b[i] = (mode == 2'd1) ? lanes[i] : tri_sample(phase, step, i);
		end
		return b;
	endfunction

	task automatic reload_lanes;
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			m_lanes[i] = seed_of_lane(m_seed, i);
		end
	endtask

	////////////////////
	// AXI4-Lite host.

	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		#1;
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = '1;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		do begin
			@(posedge clk);
		end while (!s_awready);
		a_wready: assert (s_wready) else begin
			errors++;
			$display("ERROR at %0t ns: WREADY low while AWREADY is high", $time);
		end
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		do begin
			@(posedge clk);
		end while (!s_bvalid);
		a_bresp: assert (s_bresp == 2'b00) else begin
			errors++;
			$display("ERROR at %0t ns: BRESP %b, expected OKAY", $time, s_bresp);
		end
	endtask

	task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		#1;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		do begin
			@(posedge clk);
		end while (!s_arready);
		#1;
		s_arvalid = 1'b0;
		do begin
			@(posedge clk);
		end while (!s_rvalid);
		data = s_rdata;
		a_rresp: assert (s_rresp == 2'b00) else begin
			errors++;
			$display("ERROR at %0t ns: RRESP %b, expected OKAY", $time, s_rresp);
		end
	endtask

	task automatic write_ctrl(input logic [31:0] v);
		axi_write(`REG_CTRL, v);
		if (v[3]) begin
			m_mode  = 2'd0;
			m_phase = '0;
			reload_lanes();
		end else begin
			m_mode = (v[1:0] == 2'd3) ? 2'd0 : v[1:0];
			if (v[2]) begin
				reload_lanes();
			end
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] want);
		a_word: assert (got == want) else begin
			errors++;
			$display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, want);
		end
	endtask

	// a cycle with dac_rdy high in an active mode sends the current model state out.
	task automatic run_cycles(input int n, input bit random_rdy);
		for (int k = 0; k < n; k++) begin
			#1;
			if (random_rdy) begin
				rng     = lcg_next(rng);
				dac_rdy = rng[16];
			end else begin
				dac_rdy = 1'b1;
			end
			if (dac_rdy && m_mode != 2'd0) begin
				exp_q.push_back(expected_batch(m_mode, m_lanes, m_phase, m_step));
				exp_cyc_q.push_back(cyc);
				if (m_mode == 2'd1) begin
					for (int i = 0; i < `BATCH_SIZE; i++) begin
						m_lanes[i] = lfsr_step(m_lanes[i]);
					end
				end else begin
					m_phase = m_phase + phase_t'(`BATCH_SIZE * m_step);
				end
			end
			@(posedge clk);
		end
		#1;
		dac_rdy = 1'b0;
		@(posedge clk);
	endtask

	always @(negedge clk) begin
		if (rst_n && dac_valid) begin
			n_valid++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("a valid batch %h appeared at %0t ns when none was due", dac_batch, $time);
			end else begin
				exp_b = exp_q.pop_front();
				exp_c = exp_cyc_q.pop_front();
				a_batch: assert (dac_batch == exp_b) else begin
					errors++;
					$display("ERROR at %0t ns: dac_batch expected %h, observed %h",
						$time, exp_b, dac_batch);
				end
				a_latency: assert (cyc - exp_c == `DAC_STAGES) else begin
					errors++;
					$display("ERROR at %0t ns: batch latency %0d cycles, expected %0d",
						$time, cyc - exp_c, `DAC_STAGES);
				end
			end
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout: the run did not finish within %0d ns", LIMIT_NS);
		$display("Verification failed");
		$finish;
	end

	initial begin
		rst_n     = 1'b0;
		dac_rdy   = 1'b0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b1;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b1;
		errors    = 0;
		n_valid   = 0;
		rng       = 32'd22;
		m_mode    = 2'd0;
		m_seed    = '0;
		m_step    = '0;
		m_phase   = '0;
		reload_lanes();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);

		run_cycles(N_IDLE, 1'b0);
		axi_read(`REG_STATUS, rd);
		check_word("STATUS after reset", rd, 32'd0);

		// lane 2 of this seed wraps to zero.
		m_seed = 16'hFFFE;
		axi_write(`REG_SEED, 32'h0000_FFFE);
		write_ctrl(32'h5);
		run_cycles(N_NOISE, 1'b0);

		m_step = 16'h3A5F;
		axi_write(`REG_STEP, 32'h0000_3A5F);
		write_ctrl(32'h2);
		run_cycles(N_TRI, 1'b0);

		write_ctrl(32'h1);
		run_cycles(N_RAND, 1'b1);

		////////////////////
		// halt and resume.
		write_ctrl(32'h8);
		repeat (N_DRAIN) @(posedge clk);
		axi_read(`REG_STATUS, rd);
		check_word("STATUS after halt", rd, {n_valid[15:0], 16'd0});
		write_ctrl(32'h2);
		run_cycles(N_RESUME, 1'b1);
		write_ctrl(32'h1);
		run_cycles(N_RESUME, 1'b1);
		write_ctrl(32'h8);
		repeat (N_DRAIN) @(posedge clk);
		axi_read(`REG_CTRL, rd);
		check_word("CTRL after halt", rd, 32'd0);
		axi_read(`REG_STATUS, rd);
		check_word("STATUS at the end", rd, {n_valid[15:0], 16'd0});

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected batches never appeared on dac_batch", exp_q.size());
		end
		$display("errors %0d, valid batches %0d", errors, n_valid);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: source/sample_gen_top.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module sample_gen_top import sample_gen_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`AXI_ADDR_W-1:0]   s_awaddr,
	input  logic                     s_awvalid,
	output logic                     s_awready,
	input  logic [`AXI_DATA_W-1:0]   s_wdata,
	input  logic [`AXI_DATA_W/8-1:0] s_wstrb,
	input  logic                     s_wvalid,
	output logic                     s_wready,
	output logic [1:0]               s_bresp,
	output logic                     s_bvalid,
	input  logic                     s_bready,
	input  logic [`AXI_ADDR_W-1:0]   s_araddr,
	input  logic                     s_arvalid,
	output logic                     s_arready,
	output logic [`AXI_DATA_W-1:0]   s_rdata,
	output logic [1:0]               s_rresp,
	output logic                     s_rvalid,
	input  logic                     s_rready,
	input  logic                     dac_rdy,
	output batch_t                   dac_batch,
	output logic                     dac_valid
);

	gen_mode_t mode;
	sample_t   seed;
	sample_t   step;

	batch_if noise_if ();
	batch_if tri_if ();

	sample_ctrl i_ctrl (
		.clk(clk), .rst_n(rst_n),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.dac_rdy(dac_rdy), .mode(mode), .seed(seed), .step(step),
		.noise(noise_if), .tri_wave(tri_if)
	);

	lfsr_bank i_noise (.clk(clk), .rst_n(rst_n), .seed(seed), .lanes(noise_if));

	triangle_gen i_tri (.clk(clk), .rst_n(rst_n), .step(step), .wave(tri_if));

	batch_pipe i_pipe (
		.clk(clk), .rst_n(rst_n), .mode(mode),
		.noise(noise_if), .tri_wave(tri_if),
		.dac_batch(dac_batch), .dac_valid(dac_valid)
	);

endmodule

// File: source/batch_pipe.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module batch_pipe import sample_gen_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  gen_mode_t mode,
	batch_if.sink     noise,
	batch_if.sink     tri_wave,
	output batch_t    dac_batch,
	output logic      dac_valid
);

	batch_t                 sel_batch;
	logic                   sel_valid;
	batch_t                 data_q [`DAC_STAGES];
	logic [`DAC_STAGES-1:0] valid_q;

	always_comb begin
		case (mode)
			MODE_NOISE: begin
				sel_batch = noise.batch;
				sel_valid = noise.valid;
			end
			MODE_TRIANGLE: begin
				sel_batch = tri_wave.batch;
				sel_valid = tri_wave.valid;
			end
			default: begin
				sel_batch = '0;
				sel_valid = 1'b0;
			end
		endcase
	end

	////////////////////
	// fixed delay line that stands in for the DAC latency.

	always_ff @(posedge clk) begin
		data_q[0] <= sel_batch;
		for (int s = 1; s < `DAC_STAGES; s++) begin
			data_q[s] <= data_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[`DAC_STAGES-2:0], sel_valid};
		end
	end

	assign dac_batch = data_q[`DAC_STAGES-1];
	assign dac_valid = valid_q[`DAC_STAGES-1];

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(dac_valid));

endmodule

// File: source/triangle_gen.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module triangle_gen import sample_gen_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  sample_t step,
	batch_if.source wave
);

	localparam int PHASE_W = `SAMPLE_W + 1;

	logic [PHASE_W-1:0] phase_q;
	logic [PHASE_W-1:0] lane_ph [`BATCH_SIZE];
	batch_t             tri_batch;

	// the top phase bit selects the falling half of the period.
	always_comb begin
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			lane_ph[i] = phase_q + PHASE_W'(i * step);
			if (lane_ph[i][PHASE_W-1]) begin
				tri_batch[i] = ~lane_ph[i][`SAMPLE_W-1:0];
			end else begin
				tri_batch[i] = lane_ph[i][`SAMPLE_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || wave.clear) begin
			phase_q <= '0;
		end else if (wave.run) begin
			phase_q <= phase_q + PHASE_W'(`BATCH_SIZE * step);
		end
	end

	assign wave.batch = tri_batch;
	assign wave.valid = wave.run;

endmodule

// File: source/lfsr_bank.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module lfsr_bank import sample_gen_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  sample_t seed,
	batch_if.source lanes
);

	batch_t lane_q;

	// each lane starts one above its neighbour so the lanes never run in step.
	always_ff @(posedge clk) begin
		if (!rst_n || lanes.clear) begin
			for (int i = 0; i < `BATCH_SIZE; i++) begin
				lane_q[i] <= lane_seed(seed, i);
			end
		end else if (lanes.run) begin
			for (int i = 0; i < `BATCH_SIZE; i++) begin
				lane_q[i] <= lfsr_next(lane_q[i]);
			end
		end
	end

	assign lanes.batch = lane_q;
	assign lanes.valid = lanes.run;

	// a zero lane would stay at zero forever.
	for (genvar g = 0; g < `BATCH_SIZE; g++) begin : g_lane_chk
		a_lane_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
			lane_q[g] != '0);
	end

endmodule

// File: source/sample_ctrl.sv
`timescale 1ns/1ns
`include "sample_gen_cfg.svh"

module sample_ctrl import sample_gen_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`AXI_ADDR_W-1:0]  s_awaddr,
	input  logic                    s_awvalid,
	output logic                    s_awready,
	input  logic [`AXI_DATA_W-1:0]  s_wdata,
	input  logic [`AXI_DATA_W/8-1:0] s_wstrb,
	input  logic                    s_wvalid,
	output logic                    s_wready,
	output logic [1:0]              s_bresp,
	output logic                    s_bvalid,
	input  logic                    s_bready,
	input  logic [`AXI_ADDR_W-1:0]  s_araddr,
	input  logic                    s_arvalid,
	output logic                    s_arready,
	output logic [`AXI_DATA_W-1:0]  s_rdata,
	output logic [1:0]              s_rresp,
	output logic                    s_rvalid,
	input  logic                    s_rready,
	input  logic                    dac_rdy,
	output gen_mode_t               mode,
	output sample_t                 seed,
	output sample_t                 step,
	batch_if.ctrl                   noise,
	batch_if.ctrl                   tri_wave
);

	logic                   wr_take;
	logic                   rd_take;
	gen_mode_t              wr_mode;
	logic [15:0]            batch_cnt;
	logic [`AXI_DATA_W-1:0] rd_word;

	assign wr_take = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
	assign rd_take = s_arvalid && !s_arready && !s_rvalid;

	assign s_bresp = 2'b00;
	assign s_rresp = 2'b00;

	// code 3 is not a mode and falls back to idle.
	always_comb begin
		case (s_wdata[1:0])
			2'd1:    wr_mode = MODE_NOISE;
			2'd2:    wr_mode = MODE_TRIANGLE;
			default: wr_mode = MODE_IDLE;
		endcase
	end

	////////////////////
	// write channel and registers.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_awready      <= 1'b0;
			s_wready       <= 1'b0;
			s_bvalid       <= 1'b0;
			mode           <= MODE_IDLE;
			seed           <= '0;
			step           <= '0;
			noise.clear    <= 1'b1;
			tri_wave.clear <= 1'b1;
		end else begin
			s_awready      <= wr_take;
			s_wready       <= wr_take;
			noise.clear    <= 1'b0;
			tri_wave.clear <= 1'b0;
			if (s_bvalid && s_bready) begin
				s_bvalid <= 1'b0;
			end
			if (s_awready) begin
				s_bvalid <= 1'b1;
				if (is_reg(s_awaddr, `REG_CTRL) && s_wstrb[0]) begin
					if (s_wdata[3]) begin
						mode           <= MODE_IDLE;
						noise.clear    <= 1'b1;
						tri_wave.clear <= 1'b1;
					end else begin
						mode <= wr_mode;
						if (s_wdata[2]) begin
							noise.clear <= 1'b1;
						end
					end
				end
				for (int b = 0; b < `SAMPLE_W / 8; b++) begin
					if (s_wstrb[b] && is_reg(s_awaddr, `REG_SEED)) begin
						seed[b*8 +: 8] <= s_wdata[b*8 +: 8];
					end
					if (s_wstrb[b] && is_reg(s_awaddr, `REG_STEP)) begin
						step[b*8 +: 8] <= s_wdata[b*8 +: 8];
					end
				end
			end
		end
	end

	////////////////////
	// read channel.

	always_comb begin
		rd_word = '0;
		if (is_reg(s_araddr, `REG_CTRL)) begin
			rd_word[1:0] = mode;
		end else if (is_reg(s_araddr, `REG_SEED)) begin
			rd_word[`SAMPLE_W-1:0] = seed;
		end else if (is_reg(s_araddr, `REG_STEP)) begin
			rd_word[`SAMPLE_W-1:0] = step;
		end else if (is_reg(s_araddr, `REG_STATUS)) begin
			rd_word = status_word(mode, batch_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
		end else begin
			s_arready <= rd_take;
			if (s_arready) begin
				s_rvalid <= 1'b1;
			end else if (s_rvalid && s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_arready) begin
			s_rdata <= rd_word;
		end
	end

	////////////////////
	// source gating.

	assign noise.run    = (mode == MODE_NOISE) && dac_rdy;
	assign tri_wave.run = (mode == MODE_TRIANGLE) && dac_rdy;

	// every cycle with a running source puts one valid batch into the output line.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			batch_cnt <= '0;
		end else if (noise.run || tri_wave.run) begin
			batch_cnt <= batch_cnt + 16'd1;
		end
	end

	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		mode inside {MODE_IDLE, MODE_NOISE, MODE_TRIANGLE});

endmodule

// File: source/batch_if.sv
`timescale 1ns/1ns

interface batch_if import sample_gen_pkg::*; ();

	logic   run;
	logic   clear;
	batch_t batch;
	logic   valid;

	modport source (
		input  run,
		input  clear,
		output batch,
		output valid
	);

	modport ctrl (output run, output clear);

	modport sink (input batch, input valid);

endinterface

// File: source/sample_gen_pkg.sv
`include "sample_gen_cfg.svh"

package sample_gen_pkg;

	typedef enum logic [1:0] {
		MODE_IDLE     = 2'd0,
		MODE_NOISE    = 2'd1,
		MODE_TRIANGLE = 2'd2
	} gen_mode_t;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	// lane 0 sits in the low bits.
	typedef sample_t [`BATCH_SIZE-1:0] batch_t;

	typedef logic [`AXI_ADDR_W-1:0] reg_addr_t;

	// right-shifting galois step, taps at 16, 14, 13 and 11.
	function automatic sample_t lfsr_next(input sample_t s);
		sample_t n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ sample_t'(16'hB400);
		end
		return n;
	endfunction

	// an all-zero state would lock the LFSR, so it is replaced by 1.
	function automatic sample_t lane_seed(input sample_t seed, input int unsigned lane);
		sample_t s;
		s = seed + sample_t'(lane);
		if (s == '0) begin
			s = sample_t'(1);
		end
		return s;
	endfunction

	// registers are word aligned, the byte lane bits are ignored.
	function automatic logic is_reg(input reg_addr_t addr, input reg_addr_t offset);
		return addr[`AXI_ADDR_W-1:2] == offset[`AXI_ADDR_W-1:2];
	endfunction

	function automatic logic [`AXI_DATA_W-1:0] status_word(input gen_mode_t m,
			input logic [15:0] count);
		return {count, 14'd0, m};
	endfunction

endpackage

// File: source/sample_gen_cfg.svh
`ifndef SAMPLE_GEN_CFG_SVH
`define SAMPLE_GEN_CFG_SVH

// sample and batch geometry.
`define SAMPLE_W    16
`define BATCH_SIZE  4

// output latency towards the DAC, in clock cycles.
`define DAC_STAGES  5

`define AXI_ADDR_W  4
`define AXI_DATA_W  32

// register byte offsets.
`define REG_CTRL    4'h0
`define REG_SEED    4'h4
`define REG_STEP    4'h8
`define REG_STATUS  4'hC

`endif
